/* Bender.yml */
package:
  name: dbg_subsys

sources:
  - source/dbg_ring_pkg.sv
  - source/debug_ring_slave.sv
  - source/debug_ring_master.sv
  - source/dbg_reg_bank.sv
  - source/dbg_event_probe.sv
  - source/dbg_subsys.sv
  - target: test
    files:
      - test/tb_dbg_subsys.sv

/* source/dbg_event_probe.sv */
`timescale 1ns/10ps

module dbg_event_probe (
    input  logic                                      mclk,
    input  logic                                      mrst,
    input  logic [dbg_ring_pkg::dbg_probe_events-1:0] events,    // design events
    input  dbg_ring_pkg::dbg_probe_ctrl_t             ctrl,      // received ring word
    input  logic                                      ctrl_stb,  // slave strobe
    output dbg_ring_pkg::dbg_probe_stat_t             stat       // count, to the ring
);
    import dbg_ring_pkg::*;

    logic                        enable;  // counting on
    logic [dbg_probe_events-1:0] mask;    // events that count
    logic [dbg_count_width-1:0]  count;
    logic                        hit;     // any masked event this cycle

    assign hit        = enable & (|(events & mask));
    assign stat.count = count;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            enable <= 1'b0;
            mask   <= '0;
        end else if (ctrl_stb) begin
            enable <= ctrl.enable;   // takes effect from the next cycle
            mask   <= ctrl.mask;
        end
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            count <= '0;
        end else if (ctrl_stb && ctrl.clear) begin
            count <= '0;             // clear wins over a hit in the same cycle
        end else if (hit) begin
            count <= count + 1'b1;   // one per cycle, however many bits hit
        end
    end

endmodule

/* source/dbg_reg_bank.sv */
`timescale 1ns/10ps

module dbg_reg_bank (
    input  logic                          mclk,
    input  logic                          mrst,
    input  dbg_ring_pkg::dbg_reg_cmd_t    cmd,      // received ring word
    input  logic                          cmd_stb,  // slave strobe
    output dbg_ring_pkg::dbg_reg_rdback_t rdback,   // selected register, to the ring
    output logic [dbg_ring_pkg::dbg_num_regs*dbg_ring_pkg::dbg_reg_data_width-1:0] regs_flat
);
    import dbg_ring_pkg::*;

    logic [dbg_reg_data_width-1:0] regs [dbg_num_regs];  // control registers
    logic [dbg_reg_addr_width-1:0] sel_addr;             // last addressed register

    always_ff @(posedge mclk) begin
        if (mrst) begin
            for (int i = 0; i < dbg_num_regs; i++) begin
                regs[i] <= '0;
            end
            sel_addr <= '0;
        end else if (cmd_stb) begin
            if (cmd.wr_en) begin
                regs[cmd.addr] <= cmd.data;         // write on the strobe itself
            end
            sel_addr <= cmd.addr;                   // every strobe selects
        end
    end

    // readback follows the bank directly, so a load sees pre-strobe state
    always_comb begin
        rdback.addr = sel_addr;
        rdback.pad  = '0;
        rdback.data = regs[sel_addr];
    end

    // register i sits at bits 16*i and up
    always_comb begin
        for (int i = 0; i < dbg_num_regs; i++) begin
            regs_flat[i*dbg_reg_data_width +: dbg_reg_data_width] = regs[i];
        end
    end

endmodule

/* source/dbg_ring_pkg.sv */
package dbg_ring_pkg;

    // ring geometry
    localparam int unsigned dbg_shift_width = 32;  // bits per slave shift register
    localparam int unsigned dbg_num_slaves  = 2;   // register bank, then probe
    localparam int unsigned dbg_ring_width  = dbg_num_slaves * dbg_shift_width;  // 64
    localparam int unsigned dbg_cmd_latency = 2;   // select pipeline depth in each slave

    // slot counter of the master, one count per shift slot plus the load slot
    localparam int unsigned dbg_slot_bits = $clog2(dbg_ring_width + 1);
    typedef logic [dbg_slot_bits-1:0] dbg_slot_t;
    localparam dbg_slot_t dbg_load_slot = dbg_slot_t'(dbg_ring_width);  // last slot loads

    // register bank geometry
    localparam int unsigned dbg_num_regs       = 8;
    localparam int unsigned dbg_reg_addr_width = 3;
    localparam int unsigned dbg_reg_data_width = 16;

    // probe geometry
    localparam int unsigned dbg_probe_events = 8;   // event inputs under the mask
    localparam int unsigned dbg_count_width  = 32;

    // one full ring transaction, low half ends in the probe slave
    typedef logic [dbg_ring_width-1:0] dbg_ring_word_t;

    // register bank command, received by slave 0
    typedef struct packed {
        logic                          wr_en;  // write data to addr on strobe
        logic [dbg_reg_addr_width-1:0] addr;   // also becomes the selected address
        logic [11:0]                   pad;
        logic [dbg_reg_data_width-1:0] data;
    } dbg_reg_cmd_t;

    // register bank readback, captured by slave 0 at load
    typedef struct packed {
        logic [dbg_reg_addr_width-1:0] addr;   // echo of the selected address
        logic [12:0]                   pad;
        logic [dbg_reg_data_width-1:0] data;   // contents of the selected register
    } dbg_reg_rdback_t;

    // probe control, received by slave 1
    typedef struct packed {
        logic                        clear;   // zero the count on strobe
        logic                        enable;  // count only while set
        logic [21:0]                 pad;
        logic [dbg_probe_events-1:0] mask;    // events that take part
    } dbg_probe_ctrl_t;

    // probe status, captured by slave 1 at load
    typedef struct packed {
        logic [dbg_count_width-1:0] count;
    } dbg_probe_stat_t;

endpackage

/* source/dbg_subsys.sv */
`timescale 1ns/10ps

module dbg_subsys (
    input  logic                                      mclk,
    input  logic                                      mrst,
    input  logic                                      start,
    input  dbg_ring_pkg::dbg_ring_word_t              wr_word,
    output dbg_ring_pkg::dbg_ring_word_t              rd_word,
    output logic                                      busy,
    output logic                                      done,
    input  logic [dbg_ring_pkg::dbg_probe_events-1:0] events,
    output logic [dbg_ring_pkg::dbg_num_regs*dbg_ring_pkg::dbg_reg_data_width-1:0] regs_flat
);
    import dbg_ring_pkg::*;

    logic            ring_sl;    // select to both slaves
    logic            ring_d0;    // master to slave 0
    logic            ring_d1;    // slave 0 to slave 1
    logic            ring_ret;   // slave 1 back to master
    dbg_reg_cmd_t    reg_cmd;
    dbg_reg_rdback_t reg_rdback;
    logic            reg_stb;
    dbg_probe_ctrl_t probe_ctrl;
    dbg_probe_stat_t probe_stat;
    logic            probe_stb;

    debug_ring_master i_master (
        .mclk     (mclk),
        .mrst     (mrst),
        .start    (start),
        .wr_word  (wr_word),
        .rd_word  (rd_word),
        .busy     (busy),
        .done     (done),
        .debug_sl (ring_sl),
        .debug_do (ring_d0),
        .debug_di (ring_ret)
    );

    // first on the ring, carries the high half
    debug_ring_slave #(
        .rd_t (dbg_reg_rdback_t),
        .wr_t (dbg_reg_cmd_t)
    ) i_slave_reg (
        .mclk     (mclk),
        .mrst     (mrst),
        .debug_di (ring_d0),
        .debug_sl (ring_sl),
        .debug_do (ring_d1),
        .rd_data  (reg_rdback),
        .wr_data  (reg_cmd),
        .stb      (reg_stb)
    );

    // last on the ring, carries the low half
    debug_ring_slave #(
        .rd_t (dbg_probe_stat_t),
        .wr_t (dbg_probe_ctrl_t)
    ) i_slave_probe (
        .mclk     (mclk),
        .mrst     (mrst),
        .debug_di (ring_d1),
        .debug_sl (ring_sl),
        .debug_do (ring_ret),
        .rd_data  (probe_stat),
        .wr_data  (probe_ctrl),
        .stb      (probe_stb)
    );

    dbg_reg_bank i_reg_bank (
        .mclk      (mclk),
        .mrst      (mrst),
        .cmd       (reg_cmd),
        .cmd_stb   (reg_stb),
        .rdback    (reg_rdback),
        .regs_flat (regs_flat)
    );

    dbg_event_probe i_probe (
        .mclk     (mclk),
        .mrst     (mrst),
        .events   (events),
        .ctrl     (probe_ctrl),
        .ctrl_stb (probe_stb),
        .stat     (probe_stat)
    );

endmodule

/* source/debug_ring_master.sv */
`timescale 1ns/10ps

module debug_ring_master (
    input  logic                         mclk,
    input  logic                         mrst,
    input  logic                         start,     // host request, ignored while busy
    input  dbg_ring_pkg::dbg_ring_word_t wr_word,   // word sent around the ring
    output dbg_ring_pkg::dbg_ring_word_t rd_word,   // word returned, held until next done
    output logic                         busy,
    output logic                         done,      // one cycle at the end
    output logic                         debug_sl,  // select to all slaves
    output logic                         debug_do,  // data into slave 0
    input  logic                         debug_di   // data back from the last slave
);
    import dbg_ring_pkg::*;

    logic                       accept;     // start taken this cycle
    logic                       active;     // select sequence running
    logic                       phase;      // 0 first cycle of a slot, 1 second
    dbg_slot_t                  slot_cnt;   // current slot
    logic                       last_slot;  // load slot
    logic                       sh_req;     // shift slot seen on the select line
    logic                       ld_req;     // load slot seen on the select line
    logic [dbg_cmd_latency-1:0] sh_pipe;    // lines up shifts with the slaves
    logic [dbg_cmd_latency:0]   ld_pipe;    // one extra stage to reach done
    dbg_ring_word_t             ring_sr;    // outgoing bits at lsb, returned at msb

    assign accept    = start & ~busy;
    assign last_slot = (slot_cnt == dbg_load_slot);
    assign debug_sl  = active & (~phase | last_slot);  // 1,0 shift and 1,1 load
    assign debug_do  = ring_sr[0];

    // second cycle of a slot tells shift from load, like in the slaves
    assign sh_req = active & phase & ~last_slot;
    assign ld_req = active & phase & last_slot;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            active   <= 1'b0;
            phase    <= 1'b0;
            slot_cnt <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            sh_pipe  <= '0;
            ld_pipe  <= '0;
        end else begin
            sh_pipe <= {sh_pipe[dbg_cmd_latency-2:0], sh_req};
            ld_pipe <= {ld_pipe[dbg_cmd_latency-1:0], ld_req};
            done    <= ld_pipe[dbg_cmd_latency];  // two cycles past the slave load

            if (accept) begin
                active   <= 1'b1;
                phase    <= 1'b0;
                slot_cnt <= '0;
                busy     <= 1'b1;
            end else if (active) begin
                phase <= ~phase;
                if (phase) begin
                    if (last_slot) begin
                        active <= 1'b0;             // 130 select cycles sent
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
            end

            if (ld_pipe[dbg_cmd_latency]) begin
                busy <= 1'b0;                      // falls as done rises
            end
        end
    end

    // shift in the slaves' command cycle, sampling the bit slave 1 drops
    always_ff @(posedge mclk) begin
        if (accept) begin
            ring_sr <= wr_word;
        end else if (sh_pipe[dbg_cmd_latency-1]) begin
            ring_sr <= {debug_di, ring_sr[dbg_ring_width-1:1]};
        end
    end

    always_ff @(posedge mclk) begin
        if (ld_pipe[dbg_cmd_latency]) begin
            rd_word <= ring_sr;                    // valid in the done cycle
        end
    end

endmodule

/* source/debug_ring_slave.sv */
`timescale 1ns/10ps

module debug_ring_slave #(
    parameter type rd_t = logic [31:0],  // payload captured at the load slot
    parameter type wr_t = logic [31:0]   // payload presented at the strobe
) (
    input  logic mclk,
    input  logic mrst,
    input  logic debug_di,  // serial data from the upstream node
    input  logic debug_sl,  // 0 idle, 1 then 0 shift, 1 then 1 load
    output logic debug_do,  // serial data to the downstream node
    input  rd_t  rd_data,
    output wr_t  wr_data,
    output logic stb        // one cycle per load slot
);
    import dbg_ring_pkg::*;

    logic [dbg_shift_width-1:0] data_sr;   // ring shift register
    logic [dbg_shift_width-1:0] rd_ext;    // read payload, lsb aligned
    logic [dbg_cmd_latency-1:0] cmd_pipe;  // select line delay
    logic                       cmd_dly;   // delayed select
    logic                       cmd;       // command cycle of a slot

    assign cmd_dly  = cmd_pipe[dbg_cmd_latency-1];
    assign stb      = cmd & cmd_dly;        // second select bit high means load
    assign debug_do = data_sr[0];           // lsb leaves first
    assign wr_data  = data_sr[$bits(wr_t)-1:0];

    always_comb begin
        rd_ext = '0;                        // unused upper bits stay zero
        rd_ext[$bits(rd_t)-1:0] = rd_data;
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            cmd_pipe <= '0;
            cmd      <= 1'b0;
        end else begin
            cmd_pipe <= {cmd_pipe[dbg_cmd_latency-2:0], debug_sl};
            cmd      <= cmd_dly & ~cmd;       // toggles, so each slot fires once
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd && !cmd_dly) begin
            data_sr <= {debug_di, data_sr[dbg_shift_width-1:1]};  // new bit at msb
        end else if (cmd && cmd_dly) begin
            data_sr <= rd_ext;               // capture local payload
        end
    end

endmodule

/* src.f */
source/dbg_ring_pkg.sv
source/debug_ring_slave.sv
source/debug_ring_master.sv
source/dbg_reg_bank.sv
source/dbg_event_probe.sv
source/dbg_subsys.sv
test/tb_dbg_subsys.sv

/* test/tb_dbg_subsys.sv */
`timescale 1ns/10ps

module tb_dbg_subsys;
    import dbg_ring_pkg::*;

    localparam int reset_cycles = 16;
    localparam int num_txn      = 27;    // ring transactions in the run
    localparam int txn_budget   = 200;   // cycles allowed per transaction
    localparam int max_burst    = 40;    // longest event burst plus idle cycle
    localparam int exp_latency  = 2 * (dbg_ring_width + 1) + dbg_cmd_latency + 2;

    typedef logic [dbg_num_regs*dbg_reg_data_width-1:0] reg_view_t;

    // expected state of the whole subsystem after a transaction
    typedef struct packed {
        reg_view_t                     regs;
        logic [dbg_reg_addr_width-1:0] sel;            // selected register
        logic [dbg_count_width-1:0]    count;
        logic                          enable;
        logic [dbg_probe_events-1:0]   mask;
        dbg_ring_word_t                capture;        // payloads taken at the last load
        logic                          capture_valid;
        dbg_ring_word_t                exp_rd;         // word due with this done
        logic                          exp_valid;      // first word comes from unreset slaves
    } model_t;

    logic                        mclk = 1'b0;
    logic                        mrst;
    logic                        start;
    dbg_ring_word_t              wr_word;
    dbg_ring_word_t              rd_word;
    logic                        busy;
    logic                        done;
    logic [dbg_probe_events-1:0] events;
    reg_view_t                   regs_flat;

    integer   seed;
    model_t   model;
    model_t   exp_q[$];        // one entry per accepted start

    dbg_subsys i_dut (
        .mclk      (mclk),
        .mrst      (mrst),
        .start     (start),
        .wr_word   (wr_word),
        .rd_word   (rd_word),
        .busy      (busy),
        .done      (done),
        .events    (events),
        .regs_flat (regs_flat)
    );

    always #10 mclk = ~mclk;   // 20 ns period

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input dbg_ring_word_t got, input dbg_ring_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_regs(input reg_view_t got, input reg_view_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one transaction: both slaves load their payload, then act on the received halves
    function automatic model_t ref_step(input model_t m, input dbg_ring_word_t w);
        model_t          n;
        dbg_reg_cmd_t    rc;
        dbg_probe_ctrl_t pc;
        dbg_reg_rdback_t rb;
        dbg_probe_stat_t ps;
        n  = m;
        rc = w[dbg_ring_width-1:dbg_shift_width];   // high half ends in the register bank
        pc = w[dbg_shift_width-1:0];                // low half ends in the probe
        rb.addr  = m.sel;
        rb.pad   = '0;
        rb.data  = m.regs[m.sel*dbg_reg_data_width +: dbg_reg_data_width];
        ps.count = m.count;                          // state before the strobe
        n.exp_rd        = m.capture;                 // previous load comes back now
        n.exp_valid     = m.capture_valid;
        n.capture       = {rb, ps};
        n.capture_valid = 1'b1;
        if (rc.wr_en) begin
            n.regs[rc.addr*dbg_reg_data_width +: dbg_reg_data_width] = rc.data;
        end
        n.sel    = rc.addr;
        n.enable = pc.enable;
        n.mask   = pc.mask;
        if (pc.clear) begin
            n.count = '0;
        end
        return n;
    endfunction

    task automatic run_txn(input dbg_ring_word_t w, input bit poke);
        int          k;
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        check_flag(busy, 1'b0, "busy before start");
        model = ref_step(model, w);
        exp_q.push_back(model);
        wr_word = w;
        start   = 1'b1;
        @(negedge mclk);
        k     = 1;
        start = 1'b0;
        check_flag(busy, 1'b1, "busy after start");
        while (done !== 1'b1 && k < txn_budget) begin
            if (poke && k == 40) begin
                r_hi    = $random(seed);
                r_lo    = $random(seed);
                wr_word = {r_hi, r_lo};            // must not be taken
                start   = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(negedge mclk);
            k++;
            if (done !== 1'b1) begin
                check_flag(busy, 1'b1, "busy during transaction");
            end
        end
        start = 1'b0;
        check_count(k, exp_latency, "cycles from start to done");
        check_flag(busy, 1'b0, "busy in the done cycle");
        @(negedge mclk);
        check_flag(done, 1'b0, "done one cycle later");
    endtask

    // random events while idle, counted by the model cycle by cycle
    task automatic event_burst(input int len);
        logic [31:0] r;
        for (int c = 0; c < len; c++) begin
            r      = $random(seed);
            events = r[dbg_probe_events-1:0];
            if (model.enable && |(events & model.mask)) begin
                model.count = model.count + 1'b1;
            end
            @(negedge mclk);
        end
        events = '0;
        @(negedge mclk);
    endtask

    // checks every done against the oldest pending expectation
    always @(negedge mclk) begin
        model_t e;
        if (!mrst && done === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("done pulsed with no transaction pending at %0t ns", $time);
                abort_run();
            end
            e = exp_q.pop_front();
            check_regs(regs_flat, e.regs, "register view");
            if (e.exp_valid) begin
                check_word(rd_word, e.exp_rd, "returned ring word");
            end
        end
    end

    initial begin
        repeat (reset_cycles + 20 + num_txn * (txn_budget + max_burst + 2)) @(posedge mclk);
        $display("Run hung: the transactions did not finish in the allowed time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0]     r;
        dbg_reg_cmd_t    rc;
        dbg_probe_ctrl_t pc;
        int              len;
        seed    = 32'h5be85d33;
        mrst    = 1'b1;
        start   = 1'b0;
        wr_word = '0;
        events  = '0;
        model   = '0;
        repeat (reset_cycles) @(negedge mclk);
        mrst = 1'b0;
        @(negedge mclk);

        for (int i = 0; i < num_txn; i++) begin
            r  = $random(seed);
            rc = r;
            rc.pad = '0;
            if (i < 16) begin
                rc.wr_en = 1'b1;                   // write phase
            end else if (i < 22) begin
                rc.wr_en = 1'b0;                   // readback only
            end
            r  = $random(seed);
            pc = r;
            pc.pad    = '0;
            pc.clear  = (i == 22);
            pc.enable = !(i == 23 || i == 24);     // two disabled bursts
            run_txn({rc, pc}, (i == 25));
            r   = $random(seed);
            len = 8 + int'(r[4:0]);
            event_burst(len);
        end

        repeat (4) @(negedge mclk);                // room for a stray done
        $display("TESTS PASSED");
        $finish;
    end

endmodule
